// ==== verilog.f ====
hdl/copper_pkg.sv
hdl/copper_apb_regs.sv
hdl/copper_mem.sv
hdl/beam_counter.sv
hdl/copper_fetch.sv
hdl/copper_decode.sv
hdl/copper_exec.sv
hdl/copper_top.sv
testbench/copper_checker.sv
testbench/copper_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the copper testbench with Verilator, run it and scan the log

set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert \
        -f verilog.f \
        --top-module copper_tb \
        -o copper_sim \
    && ./obj_dir/copper_sim 2>&1 | tee sim.log \
    && ! grep -q "\*\* FAIL \*\*" sim.log \
    || { echo "simulation reported failure"; exit 1; }

echo "simulation finished"
exit 0

// ==== testbench/copper_tb.sv ====
// copper testbench
`timescale 1ns/1ns

module copper_tb;

    localparam int MEM_AWIDTH = 8;
    localparam int MEM_DEPTH  = 2**MEM_AWIDTH;
    localparam int H_TOTAL    = 64;
    localparam int V_TOTAL    = 16;
    localparam int CLK_PERIOD = 40;
    localparam int RAND_ITERS = 4;
    localparam int NUM_TESTS  = 5 + RAND_ITERS;
    localparam longint WATCHDOG_NS =
        longint'(NUM_TESTS) * 4 * H_TOTAL * V_TOTAL * CLK_PERIOD;
    localparam logic [31:0] END_INSTR = 32'h0000_0003;
    localparam logic [11:0] CTRL = copper_pkg::CTRL_ADDR;

    logic        clk;
    logic        reset_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    logic [11:0] paddr_i;
    logic [31:0] pwdata_i;
    logic [31:0] prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        reg_wr_o;
    logic [7:0]  reg_addr_o;
    logic [15:0] reg_data_o;
    logic [9:0]  beam_h_o;
    logic [9:0]  beam_v_o;

    // host view of program memory, starts as all END
    logic [31:0] shadow [0:MEM_DEPTH-1];
    logic [31:0] prog_q [$];

    int          rec_tag [$];
    logic [7:0]  rec_addr [$];
    logic [15:0] rec_data [$];
    logic [19:0] rec_pos [$];
    logic [7:0]  exp_addr [$];
    logic [15:0] exp_data [$];
    logic [19:0] exp_pos [$];

    // expected beam position for the cycle that ends at each rising edge
    logic [9:0]  model_h;
    logic [9:0]  model_v;

    int frame_cnt = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_at_start = 0;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    copper_top #(
        .MEM_AWIDTH (MEM_AWIDTH),
        .H_TOTAL    (H_TOTAL),
        .V_TOTAL    (V_TOTAL)
    ) dut (
        .clk        (clk),
        .reset_i    (reset_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .pwdata_i   (pwdata_i),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o),
        .reg_wr_o   (reg_wr_o),
        .reg_addr_o (reg_addr_o),
        .reg_data_o (reg_data_o),
        .beam_h_o   (beam_h_o),
        .beam_v_o   (beam_v_o)
    );

    // every write tagged with its frame, a frame closes after its (0,0) cycle
    always @(posedge clk) begin
        if (!reset_i) begin
            if (reg_wr_o) begin
                rec_tag.push_back(frame_cnt);
                rec_addr.push_back(reg_addr_o);
                rec_data.push_back(reg_data_o);
                rec_pos.push_back({beam_v_o, beam_h_o});
            end
            if (beam_h_o == 10'd0 && beam_v_o == 10'd0) begin
                frame_cnt++;
            end
        end
    end

    // beam sweeps H_TOTAL columns per line and V_TOTAL lines per frame
    always @(posedge clk) begin
        if (reset_i) begin
            model_h = '0;
            model_v = '0;
        end else begin
            if (beam_h_o !== model_h) begin
                errors++;
                $display("FAILED beam_h_o: got %h expected %h", beam_h_o, model_h);
                model_h = beam_h_o;
            end
            if (beam_v_o !== model_v) begin
                errors++;
                $display("FAILED beam_v_o: got %h expected %h", beam_v_o, model_v);
                model_v = beam_v_o;
            end
            if (model_h == 10'(H_TOTAL - 1)) begin
                model_h = '0;
                model_v = (model_v == 10'(V_TOTAL - 1)) ? '0 : model_v + 1'b1;
            end else begin
                model_h = model_h + 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests completed");
        $display("** FAIL **");
        $finish;
    end

    function automatic logic [31:0] wait_instr(input logic [9:0] v, input logic [9:0] h);
        return {v, h, 10'd0, copper_pkg::OP_WAIT};
    endfunction

    function automatic logic [31:0] move_instr(input logic [7:0] a, input logic [15:0] d);
        return {d, a, 6'd0, copper_pkg::OP_MOVE};
    endfunction

    // expected writes of one frame, walking the program from index 0
    function automatic void build_expected(input logic [31:0] prog [0:MEM_DEPTH-1]);
        logic [19:0] earliest;
        logic [31:0] w;
        int          pc;
        int          tv;
        int          th;
        bit          running;
        exp_addr.delete();
        exp_data.delete();
        exp_pos.delete();
        earliest = '0;
        pc = 0;
        running = 1'b1;
        while (running && pc < MEM_DEPTH) begin
            w = prog[pc];
            tv = int'(w[31:22]);
            th = int'(w[21:12]);
            if (w[1:0] == copper_pkg::OP_WAIT) begin
                // a target the beam never reaches stalls the rest of the frame
                if (tv > V_TOTAL - 1 || (tv == V_TOTAL - 1 && th > H_TOTAL - 1)) begin
                    running = 1'b0;
                end else begin
                    earliest = w[31:12];
                end
            end else if (w[1:0] == copper_pkg::OP_MOVE) begin
                exp_addr.push_back(w[15:8]);
                exp_data.push_back(w[31:16]);
                exp_pos.push_back(earliest);
            end else begin
                running = 1'b0;
            end
            pc++;
        end
    endfunction

    function automatic int count_frame(input int tag);
        int n;
        n = 0;
        foreach (rec_tag[i]) begin
            if (rec_tag[i] == tag) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        #1;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        @(negedge clk);
        rdata = prdata_o;
        err   = pslverr_o;
        if (pready_o !== 1'b1) begin
            errors++;
            $display("FAILED pready_o: got %h expected 1", pready_o);
        end
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        if (wr && addr < CTRL) begin
            shadow[addr[9:2]] = wdata;
        end
    endtask

    // rewrite the program late in a frame, once every program has stopped
    task automatic load_program();
        logic [31:0] rd;
        logic        err;
        while (!(beam_v_o == 10'd14 && beam_h_o < 10'd8)) begin
            @(negedge clk);
        end
        apb_xfer(1'b1, CTRL, 32'h0, rd, err);
        foreach (prog_q[i]) begin
            apb_xfer(1'b1, 12'(i * 4), prog_q[i], rd, err);
        end
        apb_xfer(1'b1, 12'(prog_q.size() * 4), END_INSTR, rd, err);
        apb_xfer(1'b1, CTRL, 32'h1, rd, err);
    endtask

    task automatic wait_frames(input int target);
        while (frame_cnt < target) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    task automatic compare_frame(input int tag, input bit check_start);
        int idx [$];
        int n;
        foreach (rec_tag[i]) begin
            if (rec_tag[i] == tag) begin
                idx.push_back(i);
            end
        end
        n = (idx.size() < exp_addr.size()) ? idx.size() : exp_addr.size();
        if (idx.size() != exp_addr.size()) begin
            errors++;
            $display("FAILED reg_wr_o count in frame %0d: got %0h expected %0h",
                     tag, idx.size(), exp_addr.size());
        end
        for (int i = 0; i < n; i++) begin
            if (rec_addr[idx[i]] !== exp_addr[i]) begin
                errors++;
                $display("FAILED reg_addr_o write %0d: got %h expected %h",
                         i, rec_addr[idx[i]], exp_addr[i]);
            end
            if (rec_data[idx[i]] !== exp_data[i]) begin
                errors++;
                $display("FAILED reg_data_o write %0d: got %h expected %h",
                         i, rec_data[idx[i]], exp_data[i]);
            end
            if (rec_pos[idx[i]] < exp_pos[i]) begin
                errors++;
                $display("write %0d at beam %h came before its wait target %h",
                         i, rec_pos[idx[i]], exp_pos[i]);
            end
        end
        if (check_start && idx.size() > 0 && rec_pos[idx[0]] !== {10'd0, 10'd3}) begin
            errors++;
            $display("first write of frame %0d at beam %h, not three cycles after frame start",
                     tag, rec_pos[idx[0]]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors > err_at_start) begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_at_start);
        end else begin
            $display("test %0d %s: ok", tests_run, name);
        end
        err_at_start = errors;
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        int          f;
        int unsigned r;
        int unsigned kind;
        r = $urandom(66);
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            shadow[i] = END_INSTR;
        end
        repeat (16) @(posedge clk);
        #1;
        reset_i = 1'b0;

        // reset state, disabled copper reads as halted
        apb_xfer(1'b0, CTRL, 32'h0, rd, err);
        if (rd !== 32'h2) begin
            errors++;
            $display("FAILED prdata_o: got %h expected %h", rd, 32'h2);
        end
        if (err !== 1'b0) begin
            errors++;
            $display("FAILED pslverr_o: got %h expected 0", err);
        end
        repeat (20) @(posedge clk);
        if (rec_tag.size() != 0) begin
            errors++;
            $display("FAILED reg_wr_o count: got %0h expected 0", rec_tag.size());
        end
        finish_test("reset state");

        prog_q = {move_instr(8'h10, 16'h1111), move_instr(8'h11, 16'h2222),
                  move_instr(8'h12, 16'h3333), move_instr(8'h20, 16'habcd)};
        load_program();
        f = frame_cnt;
        wait_frames(f + 3);
        build_expected(shadow);
        compare_frame(f + 1, 1'b1);
        compare_frame(f + 2, 1'b1);
        finish_test("move sequence");

        // last WAIT lies past the final line
        prog_q = {wait_instr(10'd2, 10'd10), move_instr(8'h01, 16'h0a0a),
                  move_instr(8'h02, 16'h0b0b), wait_instr(10'd5, 10'd0),
                  move_instr(8'h03, 16'h0c0c), wait_instr(10'd20, 10'd0),
                  move_instr(8'h04, 16'h0d0d)};
        load_program();
        f = frame_cnt;
        wait_frames(f + 2);
        build_expected(shadow);
        compare_frame(f + 1, 1'b0);
        finish_test("wait ordering");

        prog_q = {move_instr(8'h30, 16'h5555), move_instr(8'h31, 16'h6666)};
        load_program();
        f = frame_cnt;
        wait_frames(f + 1);
        while (beam_v_o != 10'd2) begin
            @(negedge clk);
        end
        apb_xfer(1'b0, 12'h010, 32'h0, rd, err);
        if (err !== 1'b1) begin
            errors++;
            $display("FAILED pslverr_o on memory read: got %h expected 1", err);
        end
        apb_xfer(1'b1, 12'h404, 32'h0, rd, err);
        if (err !== 1'b1) begin
            errors++;
            $display("FAILED pslverr_o on unmapped write: got %h expected 1", err);
        end
        apb_xfer(1'b0, 12'h800, 32'h0, rd, err);
        if (err !== 1'b1) begin
            errors++;
            $display("FAILED pslverr_o on unmapped read: got %h expected 1", err);
        end
        apb_xfer(1'b0, CTRL, 32'h0, rd, err);
        if (rd !== 32'h3) begin
            errors++;
            $display("FAILED prdata_o status: got %h expected %h", rd, 32'h3);
        end
        // the frame after the unmapped write still runs the loaded program
        wait_frames(f + 3);
        build_expected(shadow);
        compare_frame(f + 1, 1'b1);
        compare_frame(f + 2, 1'b1);
        finish_test("apb responses");

        while (!(beam_v_o == 10'd14 && beam_h_o < 10'd8)) begin
            @(negedge clk);
        end
        apb_xfer(1'b1, CTRL, 32'h0, rd, err);
        f = frame_cnt;
        wait_frames(f + 3);
        if (count_frame(f + 1) != 0 || count_frame(f + 2) != 0) begin
            errors++;
            $display("FAILED reg_wr_o count while disabled: got %0h expected 0",
                     count_frame(f + 1) + count_frame(f + 2));
        end
        apb_xfer(1'b1, CTRL, 32'h1, rd, err);
        f = frame_cnt;
        wait_frames(f + 2);
        build_expected(shadow);
        compare_frame(f + 1, 1'b1);
        finish_test("enable control");

        for (int t = 0; t < RAND_ITERS; t++) begin
            prog_q.delete();
            for (int i = 0; i < 12; i++) begin
                kind = $urandom_range(0, 9);
                r = $urandom;
                if (kind < 3) begin
                    // one WAIT in eight aims past the frame
                    if ($urandom_range(0, 7) == 0) begin
                        prog_q.push_back(wait_instr(10'd20, 10'(r[5:0])));
                    end else begin
                        prog_q.push_back(wait_instr(10'($urandom_range(0, 11)), 10'(r[5:0])));
                    end
                end else if (kind < 8) begin
                    prog_q.push_back(move_instr(r[15:8], r[31:16]));
                end else if (kind == 8) begin
                    prog_q.push_back({r[31:2], 2'd2});
                end else begin
                    prog_q.push_back({r[31:2], copper_pkg::OP_END});
                end
            end
            load_program();
            f = frame_cnt;
            wait_frames(f + 2);
            build_expected(shadow);
            compare_frame(f + 1, 1'b0);
            finish_test($sformatf("random program %0d", t));
        end

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== testbench/copper_checker.sv ====
// copper interface assertions
`timescale 1ns/1ns

module copper_checker (
    input logic clk,
    input logic reset_i,
    input logic psel_i,
    input logic penable_i,
    input logic pslverr_i,
    input logic mem_wr_en_i,
    input logic reg_wr_i,
    input logic cop_enable_i,
    input logic frame_start_i,
    input logic d_valid_i
);

    // an errored transfer is an access phase and never reaches program memory
    assert property (@(posedge clk) pslverr_i |-> (psel_i && penable_i && !mem_wr_en_i))
        else $error("pslverr_o raised outside an APB access cycle or with a memory write");

    assert property (@(posedge clk) disable iff (reset_i) !cop_enable_i |-> !reg_wr_i)
        else $error("reg_wr_o high while the copper is disabled");

    assert property (@(posedge clk) disable iff (reset_i) !$isunknown(reg_wr_i))
        else $error("reg_wr_o is unknown");

    // a frame start flush leaves decode empty in the next cycle
    assert property (@(posedge clk) disable iff (reset_i) frame_start_i |=> !d_valid_i)
        else $error("decode output valid right after the frame start flush");

endmodule

bind copper_top copper_checker u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pslverr_i     (pslverr_o),
    .mem_wr_en_i   (mem_wr_en),
    .reg_wr_i      (reg_wr_o),
    .cop_enable_i  (cop_enable),
    .frame_start_i (frame_start),
    .d_valid_i     (d_valid)
);

// ==== hdl/copper_top.sv ====
// copper coprocessor top level
`timescale 1ns/1ns

module copper_top #(
    parameter int MEM_AWIDTH = 8,
    parameter int H_TOTAL    = 800,
    parameter int V_TOTAL    = 525
) (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             psel_i,
    input  logic                             penable_i,
    input  logic                             pwrite_i,
    input  logic [11:0]                      paddr_i,
    input  logic [31:0]                      pwdata_i,
    output logic [31:0]                      prdata_o,
    output logic                             pready_o,
    output logic                             pslverr_o,
    output logic                             reg_wr_o,
    output logic [copper_pkg::REG_W-1:0]     reg_addr_o,
    output logic [copper_pkg::DATA_W-1:0]    reg_data_o,
    output logic [copper_pkg::POS_W-1:0]     beam_h_o,
    output logic [copper_pkg::POS_W-1:0]     beam_v_o
);

    logic                             mem_wr_en;
    logic [MEM_AWIDTH-1:0]            mem_wr_addr;
    logic [31:0]                      mem_wr_data;
    logic                             cop_enable;
    logic                             cop_halted;
    logic [copper_pkg::POS_W-1:0]     beam_h;
    logic [copper_pkg::POS_W-1:0]     beam_v;
    logic                             frame_start;
    logic                             f_valid;
    logic [31:0]                      f_instr;
    logic                             d_valid;
    logic [1:0]                       d_op;
    logic [2*copper_pkg::POS_W-1:0]   d_target;
    logic [copper_pkg::REG_W-1:0]     d_reg_addr;
    logic [copper_pkg::DATA_W-1:0]    d_data;
    logic                             ex_stall;

    assign beam_h_o = beam_h;
    assign beam_v_o = beam_v;

    copper_apb_regs #(
        .MEM_AWIDTH (MEM_AWIDTH)
    ) u_apb_regs (
        .clk           (clk),
        .reset_i       (reset_i),
        .psel_i        (psel_i),
        .penable_i     (penable_i),
        .pwrite_i      (pwrite_i),
        .paddr_i       (paddr_i),
        .pwdata_i      (pwdata_i),
        .cop_halted_i  (cop_halted),
        .prdata_o      (prdata_o),
        .pready_o      (pready_o),
        .pslverr_o     (pslverr_o),
        .mem_wr_en_o   (mem_wr_en),
        .mem_wr_addr_o (mem_wr_addr),
        .mem_wr_data_o (mem_wr_data),
        .cop_enable_o  (cop_enable)
    );

    beam_counter #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_beam (
        .clk           (clk),
        .reset_i       (reset_i),
        .beam_h_o      (beam_h),
        .beam_v_o      (beam_v),
        .frame_start_o (frame_start)
    );

    copper_fetch #(
        .MEM_AWIDTH (MEM_AWIDTH)
    ) u_fetch (
        .clk           (clk),
        .reset_i       (reset_i),
        .cop_enable_i  (cop_enable),
        .frame_start_i (frame_start),
        .stall_i       (ex_stall),
        .mem_wr_en_i   (mem_wr_en),
        .mem_wr_addr_i (mem_wr_addr),
        .mem_wr_data_i (mem_wr_data),
        .f_valid_o     (f_valid),
        .f_instr_o     (f_instr)
    );

    copper_decode u_decode (
        .clk           (clk),
        .reset_i       (reset_i),
        .cop_enable_i  (cop_enable),
        .frame_start_i (frame_start),
        .stall_i       (ex_stall),
        .f_valid_i     (f_valid),
        .f_instr_i     (f_instr),
        .d_valid_o     (d_valid),
        .d_op_o        (d_op),
        .d_target_o    (d_target),
        .d_reg_addr_o  (d_reg_addr),
        .d_data_o      (d_data)
    );

    copper_exec u_exec (
        .clk           (clk),
        .reset_i       (reset_i),
        .cop_enable_i  (cop_enable),
        .frame_start_i (frame_start),
        .d_valid_i     (d_valid),
        .d_op_i        (d_op),
        .d_target_i    (d_target),
        .d_reg_addr_i  (d_reg_addr),
        .d_data_i      (d_data),
        .beam_h_i      (beam_h),
        .beam_v_i      (beam_v),
        .stall_o       (ex_stall),
        .cop_halted_o  (cop_halted),
        .reg_wr_o      (reg_wr_o),
        .reg_addr_o    (reg_addr_o),
        .reg_data_o    (reg_data_o)
    );

endmodule

// ==== hdl/copper_exec.sv ====
// copper execute stage
`timescale 1ns/1ns

module copper_exec (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             cop_enable_i,
    input  logic                             frame_start_i,
    input  logic                             d_valid_i,
    input  logic [1:0]                       d_op_i,
    input  logic [2*copper_pkg::POS_W-1:0]   d_target_i,
    input  logic [copper_pkg::REG_W-1:0]     d_reg_addr_i,
    input  logic [copper_pkg::DATA_W-1:0]    d_data_i,
    input  logic [copper_pkg::POS_W-1:0]     beam_h_i,
    input  logic [copper_pkg::POS_W-1:0]     beam_v_i,
    output logic                             stall_o,
    output logic                             cop_halted_o,
    output logic                             reg_wr_o,
    output logic [copper_pkg::REG_W-1:0]     reg_addr_o,
    output logic [copper_pkg::DATA_W-1:0]    reg_data_o
);

    localparam int PW = copper_pkg::POS_W;

    logic          flush;
    logic          is_wait;
    logic          is_move;
    logic          is_end;
    logic          wait_met;
    logic          halted_q;
    logic [PW-1:0] tgt_v;
    logic [PW-1:0] tgt_h;

    assign flush   = frame_start_i || !cop_enable_i;
    assign is_wait = d_valid_i && (d_op_i == copper_pkg::OP_WAIT);
    assign is_move = d_valid_i && (d_op_i == copper_pkg::OP_MOVE);
    assign is_end  = d_valid_i && (d_op_i == copper_pkg::OP_END);

    assign tgt_v = d_target_i[2*PW-1:PW];
    assign tgt_h = d_target_i[PW-1:0];

    // line first, then position within the line
    assign wait_met = (beam_v_i > tgt_v) || ((beam_v_i == tgt_v) && (beam_h_i >= tgt_h));

    assign stall_o      = halted_q || is_end || (is_wait && !wait_met);
    assign cop_halted_o = halted_q || !cop_enable_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush) begin
            halted_q <= 1'b0;
            reg_wr_o <= 1'b0;
        end else begin
            if (is_end) begin
                halted_q <= 1'b1;
            end
            reg_wr_o <= is_move && !halted_q;
        end
    end

    // register write payload, qualified by reg_wr_o
    always_ff @(posedge clk) begin
        if (is_move) begin
            reg_addr_o <= d_reg_addr_i;
            reg_data_o <= d_data_i;
        end
    end

endmodule

// ==== hdl/copper_decode.sv ====
// copper instruction decode stage
`timescale 1ns/1ns

module copper_decode (
    input  logic                             clk,
    input  logic                             reset_i,
    input  logic                             cop_enable_i,
    input  logic                             frame_start_i,
    input  logic                             stall_i,
    input  logic                             f_valid_i,
    input  logic [31:0]                      f_instr_i,
    output logic                             d_valid_o,
    output logic [1:0]                       d_op_o,
    output logic [2*copper_pkg::POS_W-1:0]   d_target_o,
    output logic [copper_pkg::REG_W-1:0]     d_reg_addr_o,
    output logic [copper_pkg::DATA_W-1:0]    d_data_o
);

    copper_pkg::cop_instr_t instr;
    logic [1:0]             op;
    logic                   flush;

    assign instr = f_instr_i;
    assign flush = frame_start_i || !cop_enable_i;

    // reserved opcode folds into END
    always_comb begin
        case (instr.wt.op)
            copper_pkg::OP_WAIT: op = copper_pkg::OP_WAIT;
            copper_pkg::OP_MOVE: op = copper_pkg::OP_MOVE;
            default:             op = copper_pkg::OP_END;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush) begin
            d_valid_o <= 1'b0;
        end else if (!stall_i) begin
            d_valid_o <= f_valid_i;
        end
    end

    // payload follows the valid bit, both views are captured
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            d_op_o       <= op;
            d_target_o   <= {instr.wt.v_pos, instr.wt.h_pos};
            d_reg_addr_o <= instr.mv.reg_addr;
            d_data_o     <= instr.mv.data;
        end
    end

endmodule

// ==== hdl/copper_fetch.sv ====
// copper instruction fetch stage
`timescale 1ns/1ns

module copper_fetch #(
    parameter int MEM_AWIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  cop_enable_i,
    input  logic                  frame_start_i,
    input  logic                  stall_i,
    input  logic                  mem_wr_en_i,
    input  logic [MEM_AWIDTH-1:0] mem_wr_addr_i,
    input  logic [31:0]           mem_wr_data_i,
    output logic                  f_valid_o,
    output logic [31:0]           f_instr_o
);

    localparam int DW = copper_pkg::DATA_W;

    // an all-END word, split into its even and odd halves
    localparam logic [31:0] END_WORD = {30'b0, copper_pkg::OP_END};

    logic                  flush;
    logic                  advance;
    logic [MEM_AWIDTH-1:0] addr_q;
    logic [MEM_AWIDTH-1:0] rd_addr;
    logic                  valid_q;
    logic [DW-1:0]         even_data;
    logic [DW-1:0]         odd_data;

    assign flush   = frame_start_i || !cop_enable_i;
    assign advance = valid_q && !stall_i;

    // flush issues index 0 straight away, a stall re-reads the same word
    always_comb begin
        if (flush) begin
            rd_addr = '0;
        end else if (advance) begin
            rd_addr = addr_q + 1'b1;
        end else begin
            rd_addr = addr_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            addr_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            addr_q  <= rd_addr;
            valid_q <= cop_enable_i;
        end
    end

    copper_mem #(
        .AWIDTH (MEM_AWIDTH),
        .FILL   (END_WORD[31:16])
    ) u_even (
        .clk       (clk),
        .rd_addr_i (rd_addr),
        .wr_en_i   (mem_wr_en_i),
        .wr_addr_i (mem_wr_addr_i),
        .wr_data_i (mem_wr_data_i[31:16]),
        .rd_data_o (even_data)
    );

    copper_mem #(
        .AWIDTH (MEM_AWIDTH),
        .FILL   (END_WORD[15:0])
    ) u_odd (
        .clk       (clk),
        .rd_addr_i (rd_addr),
        .wr_en_i   (mem_wr_en_i),
        .wr_addr_i (mem_wr_addr_i),
        .wr_data_i (mem_wr_data_i[15:0]),
        .rd_data_o (odd_data)
    );

    // the word read before a flush belongs to the old frame
    assign f_valid_o = valid_q && !flush;
    assign f_instr_o = {even_data, odd_data};

endmodule

// ==== hdl/beam_counter.sv ====
// video beam position counter
`timescale 1ns/1ns

module beam_counter #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                         clk,
    input  logic                         reset_i,
    output logic [copper_pkg::POS_W-1:0] beam_h_o,
    output logic [copper_pkg::POS_W-1:0] beam_v_o,
    output logic                         frame_start_o
);

    localparam int PW = copper_pkg::POS_W;

    logic [PW-1:0] h_q;
    logic [PW-1:0] v_q;
    logic [PW-1:0] h_next;
    logic [PW-1:0] v_next;
    logic          h_wrap;
    logic          frame_start_q;

    assign h_wrap = h_q == PW'(H_TOTAL - 1);
    assign h_next = h_wrap ? '0 : h_q + 1'b1;

    always_comb begin
        v_next = v_q;
        if (h_wrap) begin
            v_next = (v_q == PW'(V_TOTAL - 1)) ? '0 : v_q + 1'b1;
        end
    end

    // frame start is registered alongside the position it marks
    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_q           <= '0;
            v_q           <= '0;
            frame_start_q <= 1'b1;
        end else begin
            h_q           <= h_next;
            v_q           <= v_next;
            frame_start_q <= (h_next == '0) && (v_next == '0);
        end
    end

    assign beam_h_o      = h_q;
    assign beam_v_o      = v_q;
    assign frame_start_o = frame_start_q;

endmodule

// ==== hdl/copper_mem.sv ====
// copper program memory half
`timescale 1ns/1ns

module copper_mem #(
    parameter int                              AWIDTH = 8,
    parameter logic [copper_pkg::DATA_W-1:0]   FILL   = '0
) (
    input  logic                          clk,
    input  logic [AWIDTH-1:0]             rd_addr_i,
    input  logic                          wr_en_i,
    input  logic [AWIDTH-1:0]             wr_addr_i,
    input  logic [copper_pkg::DATA_W-1:0] wr_data_i,
    output logic [copper_pkg::DATA_W-1:0] rd_data_o
);

    logic [copper_pkg::DATA_W-1:0] bram [0:2**AWIDTH-1];

    // power-up contents, each half gets its own fill word
    initial begin
        for (int i = 0; i < 2**AWIDTH; i++) begin
            bram[i] = FILL;
        end
    end

    // single write port and registered read, maps to block RAM
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= bram[rd_addr_i];
    end

endmodule

// ==== hdl/copper_apb_regs.sv ====
// copper APB register block
`timescale 1ns/1ns

module copper_apb_regs #(
    parameter int MEM_AWIDTH = 8
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  psel_i,
    input  logic                  penable_i,
    input  logic                  pwrite_i,
    input  logic [11:0]           paddr_i,
    input  logic [31:0]           pwdata_i,
    input  logic                  cop_halted_i,
    output logic [31:0]           prdata_o,
    output logic                  pready_o,
    output logic                  pslverr_o,
    output logic                  mem_wr_en_o,
    output logic [MEM_AWIDTH-1:0] mem_wr_addr_o,
    output logic [31:0]           mem_wr_data_o,
    output logic                  cop_enable_o
);

    logic access;
    logic is_mem;
    logic is_ctrl;
    logic enable_q;

    // address map decode, valid only in the access phase
    assign access  = psel_i && penable_i;
    assign is_mem  = paddr_i < copper_pkg::CTRL_ADDR;
    assign is_ctrl = paddr_i == copper_pkg::CTRL_ADDR;

    // no wait states
    assign pready_o = 1'b1;

    // program memory is write only from the host
    assign pslverr_o = access && ((is_mem && !pwrite_i) || (!is_mem && !is_ctrl));

    // memory write lands at the edge that ends the access cycle
    assign mem_wr_en_o   = access && pwrite_i && is_mem;
    assign mem_wr_addr_o = paddr_i[2 +: MEM_AWIDTH];
    assign mem_wr_data_o = pwdata_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enable_q <= 1'b0;
        end else if (access && pwrite_i && is_ctrl) begin
            enable_q <= pwdata_i[0];
        end
    end

    assign cop_enable_o = enable_q;

    // status readback, bit 1 is read only
    always_comb begin
        prdata_o = '0;
        if (access && !pwrite_i && is_ctrl) begin
            prdata_o = {30'b0, cop_halted_i, enable_q};
        end
    end

endmodule

// ==== hdl/copper_pkg.sv ====
// copper shared definitions
package copper_pkg;

    // beam coordinate, register address and data widths
    localparam int POS_W  = 10;
    localparam int REG_W  = 8;
    localparam int DATA_W = 16;

    // opcodes, 2'd2 is reserved and runs as END
    localparam logic [1:0] OP_WAIT = 2'd0;
    localparam logic [1:0] OP_MOVE = 2'd1;
    localparam logic [1:0] OP_END  = 2'd3;

    // control and status register, everything below it is program memory
    localparam logic [11:0] CTRL_ADDR = 12'h400;

    typedef struct packed {
        logic [POS_W-1:0] v_pos;
        logic [POS_W-1:0] h_pos;
        logic [9:0]       unused;
        logic [1:0]       op;
    } cop_wait_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [REG_W-1:0]  reg_addr;
        logic [5:0]        unused;
        logic [1:0]        op;
    } cop_move_t;

    // one instruction word, seen either as a WAIT or as a MOVE
    typedef union packed {
        cop_wait_t wt;
        cop_move_t mv;
    } cop_instr_t;

endpackage
